//--- Bender.yml
package:
  name: wb_backend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/wb_pkg.sv
      - hw/uop_decode.sv
      - hw/exec_unit.sv
      - hw/writeback_stage.sv
      - hw/backend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clkgen.sv
      - bench/tb_backend.sv

//--- bench/tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module tb_backend;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 2;
    localparam int N_TESTS         = 7;
    localparam int WATCHDOG_CYCLES = N_TESTS * 200;

    wire                clk;
    logic               rst_n;
    logic               valid_in;
    wb_pkg::op_t        opcode;
    wb_pkg::addr_t      eip_in;
    wb_pkg::word_t      src_a;
    wb_pkg::word_t      src_b;
    wb_pkg::addr_t      imm;
    wb_pkg::reg_idx_t   dest_idx;
    logic               br_pred_taken;
    logic               wbaq_full;
    logic               interrupt_in;
    logic               valid_out;
    logic               stall;
    wb_pkg::word_t      res;
    wb_pkg::reg_idx_t   reg_addr;
    logic               reg_ld;
    logic               seg_ld;
    logic               mem_ld;
    wb_pkg::addr_t      mem_addr;
    wb_pkg::word_t      mem_data;
    wb_pkg::addr_t      new_eip;
    logic               br_valid;
    logic               br_taken;
    logic               is_resteer;
    logic               final_ie_val;
    wb_pkg::ie_type_t   final_ie_type;

    int err_cnt;
    int tests_run;
    int tests_failed;

    wb_pkg::word_t    exp_res_q[$];
    wb_pkg::reg_idx_t exp_dest_q[$];
    wb_pkg::addr_t    exp_eip_q[$];

    tb_clkgen u_clk (.clk(clk));

    backend_top uut (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .opcode(opcode), .eip_in(eip_in),
        .src_a(src_a), .src_b(src_b), .imm(imm), .dest_idx(dest_idx),
        .br_pred_taken(br_pred_taken), .wbaq_full(wbaq_full), .interrupt_in(interrupt_in),
        .valid_out(valid_out), .stall(stall), .res(res), .reg_addr(reg_addr),
        .reg_ld(reg_ld), .seg_ld(seg_ld), .mem_ld(mem_ld), .mem_addr(mem_addr),
        .mem_data(mem_data), .new_eip(new_eip), .br_valid(br_valid), .br_taken(br_taken),
        .is_resteer(is_resteer), .final_ie_val(final_ie_val), .final_ie_type(final_ie_type)
    );

    task automatic check_word(input string name, input wb_pkg::word_t got,
                              input wb_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input wb_pkg::addr_t got,
                              input wb_pkg::addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_idx(input string name, input wb_pkg::reg_idx_t got,
                             input wb_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_ie(input string name, input wb_pkg::ie_type_t got,
                            input wb_pkg::ie_type_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_strobes(input logic r, input logic s, input logic m);
        check_bit("reg_ld", reg_ld, r);
        check_bit("seg_ld", seg_ld, s);
        check_bit("mem_ld", mem_ld, m);
    endtask

    function automatic wb_pkg::word_t alu_model(input wb_pkg::op_t op,
                                                input wb_pkg::word_t a, input wb_pkg::word_t b);
        case (op)
            wb_pkg::OP_SUB: return a - b;
            wb_pkg::OP_AND: return a & b;
            wb_pkg::OP_XOR: return a ^ b;
            default:        return a + b;
        endcase
    endfunction

    function automatic wb_pkg::word_t selector_zext(input wb_pkg::word_t b);
        return {{(`WB_XLEN-`WB_SEG_W){1'b0}}, b[`WB_SEG_W-1:0]};
    endfunction

    function automatic wb_pkg::ie_type_t ie_expect(input logic intr, input logic ud);
        return {intr, (ud ? 3'(`WB_IE_UD) : 3'd0)};
    endfunction

    task automatic drive_uop(input wb_pkg::op_t op, input wb_pkg::addr_t eip,
                             input wb_pkg::word_t a, input wb_pkg::word_t b,
                             input wb_pkg::addr_t target, input wb_pkg::reg_idx_t dest,
                             input logic pred);
        @(posedge clk);
        #DRIVE_DLY;
        valid_in      = 1'b1;
        opcode        = op;
        eip_in        = eip;
        src_a         = a;
        src_b         = b;
        imm           = target;
        dest_idx      = dest;
        br_pred_taken = pred;
    endtask

    // one instruction, then park at mid-cycle of its writeback
    task automatic issue_uop(input wb_pkg::op_t op, input wb_pkg::addr_t eip,
                             input wb_pkg::word_t a, input wb_pkg::word_t b,
                             input wb_pkg::addr_t target, input wb_pkg::reg_idx_t dest,
                             input logic pred);
        drive_uop(op, eip, a, b, target, dest, pred);
        @(posedge clk);
        #DRIVE_DLY;
        valid_in = 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic set_queue_full(input logic v);
        @(posedge clk);
        #DRIVE_DLY;
        wbaq_full = v;
    endtask

    task automatic set_interrupt(input logic v);
        @(posedge clk);
        #DRIVE_DLY;
        interrupt_in = v;
    endtask

    task automatic wait_for_valid(output bit seen);
        int i;
        seen = 1'b0;
        for (i = 0; i < 16 && !seen; i++) begin
            @(negedge clk);
            if (valid_out)
                seen = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %-8s ok", name);
        end else begin
            tests_failed++;
            $display("test %-8s FAILED with %0d errors", name, err_cnt - err_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        @(negedge clk);
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("stall", stall, 1'b0);
        check_strobes(1'b0, 1'b0, 1'b0);
        check_bit("is_resteer", is_resteer, 1'b0);
        check_bit("br_valid", br_valid, 1'b0);
        check_bit("final_ie_val", final_ie_val, 1'b0);
        end_test("reset", e0);
    endtask

    task automatic test_alu();
        wb_pkg::op_t      op;
        wb_pkg::word_t    a;
        wb_pkg::word_t    b;
        wb_pkg::addr_t    eip;
        wb_pkg::reg_idx_t dest;
        int               i;
        int               e0;
        e0 = err_cnt;
        for (i = 0; i < 4; i++) begin
            op   = wb_pkg::op_t'(i);
            a    = $urandom();
            b    = $urandom();
            eip  = 32'h0000_1000 + 16 * i;
            dest = wb_pkg::reg_idx_t'($urandom_range(7, 0));
            issue_uop(op, eip, a, b, 32'h0, dest, 1'b0);
            check_bit("valid_out", valid_out, 1'b1);
            check_word("res", res, alu_model(op, a, b));
            check_idx("reg_addr", reg_addr, dest);
            check_strobes(1'b1, 1'b0, 1'b0);
            check_addr("new_eip", new_eip, eip + `WB_INST_BYTES);
            check_bit("is_resteer", is_resteer, 1'b0);
            @(negedge clk);
            check_bit("reg_ld", reg_ld, 1'b0);   // single pulse
        end
        end_test("alu", e0);
    endtask

    task automatic test_seg();
        wb_pkg::word_t a;
        wb_pkg::word_t b;
        wb_pkg::addr_t eip;
        int            p;
        int            e0;
        e0  = err_cnt;
        a   = $urandom();
        b   = $urandom();
        eip = 32'h0000_3000;
        issue_uop(wb_pkg::OP_MOVSEG, eip, a, b, 32'h0, 3'd5, 1'b0);
        check_word("res", res, selector_zext(b));
        check_idx("reg_addr", reg_addr, 3'd5);
        check_strobes(1'b0, 1'b1, 1'b0);
        check_bit("br_valid", br_valid, 1'b0);
        for (p = 0; p < 2; p++) begin
            a = $urandom();
            b = $urandom();
            issue_uop(wb_pkg::OP_JMPFAR, eip, a, b, 32'h0, 3'd6, p[0]);
            check_addr("new_eip", new_eip, a);
            check_word("res", res, selector_zext(b));
            check_idx("reg_addr", reg_addr, wb_pkg::reg_idx_t'(`WB_CS_IDX));
            check_strobes(1'b0, 1'b1, 1'b0);
            check_bit("br_taken", br_taken, 1'b1);
            check_bit("is_resteer", is_resteer, !p[0]);
        end
        end_test("segment", e0);
    endtask

    task automatic test_store();
        wb_pkg::word_t data;
        wb_pkg::addr_t addr;
        bit            seen;
        int            i;
        int            n_ld;
        int            e0;
        e0   = err_cnt;
        data = $urandom();
        addr = $urandom();
        issue_uop(wb_pkg::OP_STORE, 32'h0000_2000, data, 32'h0, addr, 3'd0, 1'b0);
        check_bit("stall", stall, 1'b0);
        check_strobes(1'b0, 1'b0, 1'b1);
        check_addr("mem_addr", mem_addr, addr);
        check_word("mem_data", mem_data, data);
        set_queue_full(1'b1);
        data = $urandom();
        addr = $urandom();
        issue_uop(wb_pkg::OP_STORE, 32'h0000_2004, data, 32'h0, addr, 3'd0, 1'b0);
        for (i = 0; i < 6; i++) begin
            if (i > 0)
                @(negedge clk);
            check_bit("stall", stall, 1'b1);
            check_bit("valid_out", valid_out, 1'b0);
            check_bit("mem_ld", mem_ld, 1'b0);
        end
        set_queue_full(1'b0);
        wait_for_valid(seen);
        if (!seen) begin
            $display("store did not retire after the queue was released");
            err_cnt++;
        end else begin
            check_bit("mem_ld", mem_ld, 1'b1);
            check_addr("mem_addr", mem_addr, addr);
            check_word("mem_data", mem_data, data);
        end
        n_ld = 0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (mem_ld)
                n_ld++;
        end
        if (n_ld != 0) begin
            $display("blocked store retired %0d extra times", n_ld);
            err_cnt++;
        end
        end_test("store", e0);
    endtask

    task automatic test_jcc();
        wb_pkg::word_t a;
        wb_pkg::word_t b;
        wb_pkg::addr_t eip;
        wb_pkg::addr_t target;
        logic          eq;
        logic          pred;
        int            k;
        int            e0;
        e0 = err_cnt;
        for (k = 0; k < 4; k++) begin
            eq     = k[1];
            pred   = k[0];
            a      = $urandom();
            b      = eq ? a : a ^ 32'h0000_0010;
            eip    = 32'h0000_5000 + 32 * k;
            target = $urandom();
            issue_uop(wb_pkg::OP_JCC, eip, a, b, target, 3'd0, pred);
            check_bit("br_valid", br_valid, 1'b1);
            check_bit("br_taken", br_taken, eq);
            check_addr("new_eip", new_eip, eq ? target : eip + `WB_INST_BYTES);
            check_bit("is_resteer", is_resteer, eq != pred);
            check_strobes(1'b0, 1'b0, 1'b0);
        end
        end_test("jcc", e0);
    endtask

    task automatic test_exc();
        int e0;
        e0 = err_cnt;
        issue_uop(wb_pkg::op_t'(4'd9), 32'h0000_6000, 32'h1, 32'h2, 32'h0, 3'd2, 1'b0);
        check_bit("valid_out", valid_out, 1'b1);
        check_bit("final_ie_val", final_ie_val, 1'b1);
        check_ie("final_ie_type", final_ie_type, ie_expect(1'b0, 1'b1));
        check_strobes(1'b0, 1'b0, 1'b0);
        set_interrupt(1'b1);
        @(negedge clk);   // pipe is empty here
        check_bit("final_ie_val", final_ie_val, 1'b1);
        check_ie("final_ie_type", final_ie_type, ie_expect(1'b1, 1'b0));
        issue_uop(wb_pkg::op_t'(4'd12), 32'h0000_6004, 32'h3, 32'h4, 32'h0, 3'd2, 1'b0);
        check_bit("final_ie_val", final_ie_val, 1'b1);
        check_ie("final_ie_type", final_ie_type, ie_expect(1'b1, 1'b1));
        check_strobes(1'b0, 1'b0, 1'b0);
        set_interrupt(1'b0);
        end_test("except", e0);
    endtask

    task automatic test_stream();
        wb_pkg::op_t      op;
        wb_pkg::word_t    a;
        wb_pkg::word_t    b;
        wb_pkg::addr_t    eip;
        wb_pkg::reg_idx_t dest;
        int               k;
        int               seen;
        int               e0;
        e0   = err_cnt;
        seen = 0;
        eip  = 32'h0000_8000;
        for (k = 0; k < 34; k++) begin
            if (k < 32) begin
                op   = wb_pkg::op_t'($urandom_range(3, 0));
                a    = $urandom();
                b    = $urandom();
                dest = wb_pkg::reg_idx_t'($urandom_range(7, 0));
                drive_uop(op, eip, a, b, 32'h0, dest, 1'b0);
                exp_res_q.push_back(alu_model(op, a, b));
                exp_dest_q.push_back(dest);
                exp_eip_q.push_back(eip + `WB_INST_BYTES);
                eip = eip + `WB_INST_BYTES;
            end else begin
                @(posedge clk);
                #DRIVE_DLY;
                valid_in = 1'b0;
            end
            @(negedge clk);
            check_bit("valid_out", valid_out, k >= 2);   // two-cycle latency
            check_bit("stall", stall, 1'b0);
            if (valid_out && exp_res_q.size() == 0) begin
                $display("valid_out with no instruction outstanding");
                err_cnt++;
            end else if (valid_out) begin
                check_word("res", res, exp_res_q.pop_front());
                check_idx("reg_addr", reg_addr, exp_dest_q.pop_front());
                check_addr("new_eip", new_eip, exp_eip_q.pop_front());
                check_bit("reg_ld", reg_ld, 1'b1);
                seen++;
            end
        end
        if (seen != 32) begin
            $display("stream retired %0d of 32 instructions", seen);
            err_cnt++;
        end
        end_test("stream", e0);
    endtask

    initial begin
        rst_n         = 1'b0;
        valid_in      = 1'b0;
        opcode        = wb_pkg::OP_ADD;
        eip_in        = '0;
        src_a         = '0;
        src_b         = '0;
        imm           = '0;
        dest_idx      = '0;
        br_pred_taken = 1'b0;
        wbaq_full     = 1'b0;
        interrupt_in  = 1'b0;
        err_cnt       = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(21581));
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_seg();
        test_store();
        test_jcc();
        test_exc();
        test_stream();
        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;   // 40 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/wb_pkg.sv
hw/uop_decode.sv
hw/exec_unit.sv
hw/writeback_stage.sv
hw/backend_top.sv
bench/tb_clkgen.sv
bench/tb_backend.sv

//--- hw/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module backend_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   valid_in,
    input  wire wb_pkg::op_t      opcode,
    input  wire wb_pkg::addr_t    eip_in,
    input  wire wb_pkg::word_t    src_a,
    input  wire wb_pkg::word_t    src_b,
    input  wire wb_pkg::addr_t    imm,
    input  wire wb_pkg::reg_idx_t dest_idx,
    input  wire                   br_pred_taken,
    input  wire                   wbaq_full,
    input  wire                   interrupt_in,
    output logic                  valid_out,
    output logic                  stall,
    output wb_pkg::word_t         res,
    output wb_pkg::reg_idx_t      reg_addr,
    output logic                  reg_ld,
    output logic                  seg_ld,
    output logic                  mem_ld,
    output wb_pkg::addr_t         mem_addr,
    output wb_pkg::word_t         mem_data,
    output wb_pkg::addr_t         new_eip,
    output logic                  br_valid,
    output logic                  br_taken,
    output logic                  is_resteer,
    output logic                  final_ie_val,
    output wb_pkg::ie_type_t      final_ie_type
);

    // decode to execute
    logic             dc_valid;
    wb_pkg::alu_fn_t  dc_fn;
    logic             dc_wr_reg;
    logic             dc_wr_seg;
    logic             dc_wr_mem;
    logic             dc_is_br;
    logic             dc_is_far;
    logic             dc_ill;
    wb_pkg::addr_t    dc_eip;
    wb_pkg::word_t    dc_a;
    wb_pkg::word_t    dc_b;
    wb_pkg::addr_t    dc_imm;
    wb_pkg::reg_idx_t dc_dest;
    logic             dc_pred;

    // execute to writeback
    logic             ex_valid;
    wb_pkg::word_t    ex_res;
    wb_pkg::reg_idx_t ex_dest;
    logic             ex_wr_reg;
    logic             ex_wr_seg;
    logic             ex_wr_mem;
    wb_pkg::addr_t    ex_mem_addr;
    logic             ex_br;
    logic             ex_taken;
    logic             ex_pred;
    wb_pkg::addr_t    ex_next_eip;
    logic             ex_ill;

    uop_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .valid_in      (valid_in),
        .opcode        (opcode),
        .eip_in        (eip_in),
        .src_a         (src_a),
        .src_b         (src_b),
        .imm           (imm),
        .dest_idx      (dest_idx),
        .br_pred_taken (br_pred_taken),
        .dc_valid      (dc_valid),
        .dc_fn         (dc_fn),
        .dc_wr_reg     (dc_wr_reg),
        .dc_wr_seg     (dc_wr_seg),
        .dc_wr_mem     (dc_wr_mem),
        .dc_is_br      (dc_is_br),
        .dc_is_far     (dc_is_far),
        .dc_ill        (dc_ill),
        .dc_eip        (dc_eip),
        .dc_a          (dc_a),
        .dc_b          (dc_b),
        .dc_imm        (dc_imm),
        .dc_dest       (dc_dest),
        .dc_pred       (dc_pred)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .dc_valid    (dc_valid),
        .dc_fn       (dc_fn),
        .dc_wr_reg   (dc_wr_reg),
        .dc_wr_seg   (dc_wr_seg),
        .dc_wr_mem   (dc_wr_mem),
        .dc_is_br    (dc_is_br),
        .dc_is_far   (dc_is_far),
        .dc_ill      (dc_ill),
        .dc_eip      (dc_eip),
        .dc_a        (dc_a),
        .dc_b        (dc_b),
        .dc_imm      (dc_imm),
        .dc_dest     (dc_dest),
        .dc_pred     (dc_pred),
        .ex_valid    (ex_valid),
        .ex_res      (ex_res),
        .ex_dest     (ex_dest),
        .ex_wr_reg   (ex_wr_reg),
        .ex_wr_seg   (ex_wr_seg),
        .ex_wr_mem   (ex_wr_mem),
        .ex_mem_addr (ex_mem_addr),
        .ex_br       (ex_br),
        .ex_taken    (ex_taken),
        .ex_pred     (ex_pred),
        .ex_next_eip (ex_next_eip),
        .ex_ill      (ex_ill)
    );

    writeback_stage u_wb (
        .ex_valid      (ex_valid),
        .ex_res        (ex_res),
        .ex_dest       (ex_dest),
        .ex_wr_reg     (ex_wr_reg),
        .ex_wr_seg     (ex_wr_seg),
        .ex_wr_mem     (ex_wr_mem),
        .ex_mem_addr   (ex_mem_addr),
        .ex_br         (ex_br),
        .ex_taken      (ex_taken),
        .ex_pred       (ex_pred),
        .ex_next_eip   (ex_next_eip),
        .ex_ill        (ex_ill),
        .wbaq_full     (wbaq_full),
        .interrupt_in  (interrupt_in),
        .valid_out     (valid_out),
        .stall         (stall),
        .res           (res),
        .reg_addr      (reg_addr),
        .reg_ld        (reg_ld),
        .seg_ld        (seg_ld),
        .mem_ld        (mem_ld),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .new_eip       (new_eip),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module exec_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   stall,
    input  wire                   dc_valid,
    input  wire wb_pkg::alu_fn_t  dc_fn,
    input  wire                   dc_wr_reg,
    input  wire                   dc_wr_seg,
    input  wire                   dc_wr_mem,
    input  wire                   dc_is_br,
    input  wire                   dc_is_far,
    input  wire                   dc_ill,
    input  wire wb_pkg::addr_t    dc_eip,
    input  wire wb_pkg::word_t    dc_a,
    input  wire wb_pkg::word_t    dc_b,
    input  wire wb_pkg::addr_t    dc_imm,
    input  wire wb_pkg::reg_idx_t dc_dest,
    input  wire                   dc_pred,
    output logic                  ex_valid,
    output wb_pkg::word_t         ex_res,
    output wb_pkg::reg_idx_t      ex_dest,
    output logic                  ex_wr_reg,
    output logic                  ex_wr_seg,
    output logic                  ex_wr_mem,
    output wb_pkg::addr_t         ex_mem_addr,
    output logic                  ex_br,
    output logic                  ex_taken,
    output logic                  ex_pred,
    output wb_pkg::addr_t         ex_next_eip,
    output logic                  ex_ill
);

    wb_pkg::word_t    alu_out;
    wb_pkg::seg_val_t seg_val;
    wb_pkg::word_t    result;
    wb_pkg::addr_t    br_target;
    wb_pkg::addr_t    next_eip;
    wb_pkg::reg_idx_t dest;
    logic             taken;

    always_comb begin
        case (dc_fn)
            wb_pkg::FN_ADD: alu_out = dc_a + dc_b;
            wb_pkg::FN_SUB: alu_out = dc_a - dc_b;
            wb_pkg::FN_AND: alu_out = dc_a & dc_b;
            wb_pkg::FN_XOR: alu_out = dc_a ^ dc_b;
            default:        alu_out = dc_b;          // pass b
        endcase
    end

    assign seg_val = dc_b[`WB_SEG_W-1:0];

    // store data is src_a, selector is zero-extended
    always_comb begin
        if (dc_wr_seg)
            result = {{(`WB_XLEN-`WB_SEG_W){1'b0}}, seg_val};
        else if (dc_wr_mem)
            result = dc_a;
        else
            result = alu_out;
    end

    assign taken     = dc_is_far || (dc_is_br && (alu_out == '0));
    assign br_target = dc_is_far ? dc_a : dc_imm;
    assign next_eip  = taken ? br_target : dc_eip + `WB_INST_BYTES;
    assign dest      = dc_is_far ? wb_pkg::reg_idx_t'(`WB_CS_IDX) : dc_dest;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_wr_reg <= 1'b0;
            ex_wr_seg <= 1'b0;
            ex_wr_mem <= 1'b0;
            ex_br     <= 1'b0;
            ex_taken  <= 1'b0;
            ex_pred   <= 1'b0;
            ex_ill    <= 1'b0;
        end else if (!stall) begin
            ex_valid  <= dc_valid;
            ex_wr_reg <= dc_wr_reg;
            ex_wr_seg <= dc_wr_seg;
            ex_wr_mem <= dc_wr_mem;
            ex_br     <= dc_is_br;
            ex_taken  <= taken;
            ex_pred   <= dc_pred;
            ex_ill    <= dc_ill;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_res      <= result;
            ex_dest     <= dest;
            ex_mem_addr <= dc_imm;      // store address
            ex_next_eip <= next_eip;
        end
    end

    // a blocked store must stay put until the queue drains
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(ex_valid));

endmodule

`default_nettype wire

//--- hw/uop_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module uop_decode (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   stall,
    input  wire                   valid_in,
    input  wire wb_pkg::op_t      opcode,
    input  wire wb_pkg::addr_t    eip_in,
    input  wire wb_pkg::word_t    src_a,
    input  wire wb_pkg::word_t    src_b,
    input  wire wb_pkg::addr_t    imm,
    input  wire wb_pkg::reg_idx_t dest_idx,
    input  wire                   br_pred_taken,
    output logic                  dc_valid,
    output wb_pkg::alu_fn_t       dc_fn,
    output logic                  dc_wr_reg,
    output logic                  dc_wr_seg,
    output logic                  dc_wr_mem,
    output logic                  dc_is_br,
    output logic                  dc_is_far,
    output logic                  dc_ill,
    output wb_pkg::addr_t         dc_eip,
    output wb_pkg::word_t         dc_a,
    output wb_pkg::word_t         dc_b,
    output wb_pkg::addr_t         dc_imm,
    output wb_pkg::reg_idx_t      dc_dest,
    output logic                  dc_pred
);

    wb_pkg::alu_fn_t fn;
    logic            wr_reg;
    logic            wr_seg;
    logic            wr_mem;
    logic            is_br;
    logic            is_far;
    logic            ill;

    always_comb begin
        fn     = wb_pkg::FN_ADD;
        wr_reg = 1'b0;
        wr_seg = 1'b0;
        wr_mem = 1'b0;
        is_br  = 1'b0;
        is_far = 1'b0;
        ill    = 1'b0;
        case (opcode)
            wb_pkg::OP_ADD:    wr_reg = 1'b1;
            wb_pkg::OP_SUB: begin
                fn     = wb_pkg::FN_SUB;
                wr_reg = 1'b1;
            end
            wb_pkg::OP_AND: begin
                fn     = wb_pkg::FN_AND;
                wr_reg = 1'b1;
            end
            wb_pkg::OP_XOR: begin
                fn     = wb_pkg::FN_XOR;
                wr_reg = 1'b1;
            end
            wb_pkg::OP_MOVSEG: begin
                fn     = wb_pkg::FN_PASS_B;
                wr_seg = 1'b1;
            end
            wb_pkg::OP_STORE:  wr_mem = 1'b1;
            wb_pkg::OP_JCC: begin
                fn    = wb_pkg::FN_SUB;   // zero difference means equal
                is_br = 1'b1;
            end
            wb_pkg::OP_JMPFAR: begin
                fn     = wb_pkg::FN_PASS_B;
                wr_seg = 1'b1;            // CS load
                is_br  = 1'b1;
                is_far = 1'b1;
            end
            default:           ill = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_valid  <= 1'b0;
            dc_wr_reg <= 1'b0;
            dc_wr_seg <= 1'b0;
            dc_wr_mem <= 1'b0;
            dc_is_br  <= 1'b0;
            dc_is_far <= 1'b0;
            dc_ill    <= 1'b0;
            dc_pred   <= 1'b0;
        end else if (!stall) begin
            dc_valid  <= valid_in;
            dc_wr_reg <= wr_reg;
            dc_wr_seg <= wr_seg;
            dc_wr_mem <= wr_mem;
            dc_is_br  <= is_br;
            dc_is_far <= is_far;
            dc_ill    <= ill;
            dc_pred   <= br_pred_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dc_fn   <= fn;
            dc_eip  <= eip_in;
            dc_a    <= src_a;
            dc_b    <= src_b;
            dc_imm  <= imm;
            dc_dest <= dest_idx;
        end
    end

    a_one_dest_kind: assert property (@(posedge clk) disable iff (!rst_n)
        dc_valid |-> $onehot0({dc_wr_reg, dc_wr_seg, dc_wr_mem}));

endmodule

`default_nettype wire

//--- hw/wb_pkg.sv
`default_nettype none

`include "wb_cfg.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0]      word_t;
    typedef logic [`WB_XLEN-1:0]      addr_t;
    typedef logic [`WB_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`WB_SEG_W-1:0]     seg_val_t;
    typedef logic [`WB_IE_TYPE_W-1:0] ie_type_t;   // [3] interrupt, [2:0] code

    // codes 8..15 are undefined
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_XOR    = 4'd3,
        OP_MOVSEG = 4'd4,
        OP_STORE  = 4'd5,
        OP_JCC    = 4'd6,
        OP_JMPFAR = 4'd7
    } op_t;

    typedef enum logic [2:0] {
        FN_ADD    = 3'd0,
        FN_SUB    = 3'd1,
        FN_AND    = 3'd2,
        FN_XOR    = 3'd3,
        FN_PASS_B = 3'd4
    } alu_fn_t;

endpackage

`default_nettype wire

//--- hw/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module writeback_stage (
    input  wire                   ex_valid,
    input  wire wb_pkg::word_t    ex_res,
    input  wire wb_pkg::reg_idx_t ex_dest,
    input  wire                   ex_wr_reg,
    input  wire                   ex_wr_seg,
    input  wire                   ex_wr_mem,
    input  wire wb_pkg::addr_t    ex_mem_addr,
    input  wire                   ex_br,
    input  wire                   ex_taken,
    input  wire                   ex_pred,
    input  wire wb_pkg::addr_t    ex_next_eip,
    input  wire                   ex_ill,
    input  wire                   wbaq_full,
    input  wire                   interrupt_in,
    output logic                  valid_out,
    output logic                  stall,
    output wb_pkg::word_t         res,
    output wb_pkg::reg_idx_t      reg_addr,
    output logic                  reg_ld,
    output logic                  seg_ld,
    output logic                  mem_ld,
    output wb_pkg::addr_t         mem_addr,
    output wb_pkg::word_t         mem_data,
    output wb_pkg::addr_t         new_eip,
    output logic                  br_valid,
    output logic                  br_taken,
    output logic                  is_resteer,
    output logic                  final_ie_val,
    output wb_pkg::ie_type_t      final_ie_type
);

    logic store_pending;
    logic mispredict;
    logic exc_pending;

    // back-pressure from the address queue
    assign store_pending = ex_valid && ex_wr_mem;
    assign stall         = store_pending && wbaq_full;
    assign valid_out     = ex_valid && !stall;

    // strobes only fire for a retiring instruction
    assign reg_ld = valid_out && ex_wr_reg;
    assign seg_ld = valid_out && ex_wr_seg;
    assign mem_ld = valid_out && ex_wr_mem;

    assign res      = ex_res;
    assign reg_addr = ex_dest;       // shared by reg and seg writes
    assign mem_addr = ex_mem_addr;
    assign mem_data = ex_res;

    // branch outcome
    assign br_valid   = valid_out && ex_br;
    assign br_taken   = valid_out && ex_taken;
    assign mispredict = ex_taken != ex_pred;
    assign is_resteer = br_valid && mispredict;
    assign new_eip    = ex_next_eip;   // target or fall-through from execute

    // exception merge
    assign exc_pending  = valid_out && ex_ill;
    assign final_ie_val = exc_pending || interrupt_in;

    always_comb begin
        final_ie_type[3] = interrupt_in;
        if (exc_pending)
            final_ie_type[2:0] = 3'(`WB_IE_UD);
        else
            final_ie_type[2:0] = 3'd0;
    end

endmodule

`default_nettype wire

//--- include/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// datapath and index widths
`define WB_XLEN        32
`define WB_REG_IDX_W   3
`define WB_SEG_W       16
`define WB_IE_TYPE_W   4

`define WB_INST_BYTES  4    // fall-through step of a fixed-length instruction

`define WB_CS_IDX      1    // segment loaded by far jump

// exception codes in the low bits of final_ie_type
`define WB_IE_UD       6

`endif
